/* hdl/int_pkg.sv */
`default_nettype none

package int_pkg;

    // Data path width for operands, results, PCs and branch targets
    typedef logic [63:0] word_t;

    // Architectural destination register index
    typedef logic [4:0] reg_idx_t;

    // Signed immediate that decode attaches to every branch
    typedef logic signed [20:0] br_off_t;

    // ALU function select
    // The option bit turns op_add into a subtract and op_srl into an arithmetic shift
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sll  = 4'd1,
        op_slt  = 4'd2,
        op_sltu = 4'd3,
        op_xor  = 4'd4,
        op_srl  = 4'd5,
        op_or   = 4'd6,
        op_and  = 4'd7,
        op_eq   = 4'd8
    } alu_op_e;

    // Branch kind as seen by the resolver
    // For JAL and JALR the ALU produces the link value pc + 4
    // For a conditional branch the ALU produces the compare bit
    typedef enum logic [1:0] {
        bt_none  = 2'd0,
        bt_jal   = 2'd1,
        bt_jalr  = 2'd2,
        bt_bcond = 2'd3
    } br_type_e;

endpackage

`default_nettype wire

/* hdl/alu.sv */
`default_nettype none

module alu (
    input  int_pkg::alu_op_e op,
    input  logic             option,
    input  int_pkg::word_t   operand1,
    input  int_pkg::word_t   operand2,
    output int_pkg::word_t   result
);
    import int_pkg::*;

    logic [5:0] shamt;
    word_t      add_sub;
    word_t      shr;
    logic       lt_signed;
    logic       lt_unsigned;

    // RV64 shifts only look at the low six bits of the amount
    assign shamt = operand2[5:0];

    assign add_sub = option ? (operand1 - operand2) : (operand1 + operand2);

    // The arithmetic shift must stay in a signed context of its own
    always_comb begin
        if (option) begin
            shr = $signed(operand1) >>> shamt;
        end else begin
            shr = operand1 >> shamt;
        end
    end

    assign lt_signed   = $signed(operand1) < $signed(operand2);
    assign lt_unsigned = operand1 < operand2;

    always_comb begin
        case (op)
            op_add:  result = add_sub;
            op_sll:  result = operand1 << shamt;
            // Compare results are a single flag in bit 0
            op_slt:  result = {63'd0, lt_signed};
            op_sltu: result = {63'd0, lt_unsigned};
            op_xor:  result = operand1 ^ operand2;
            op_srl:  result = shr;
            op_or:   result = operand1 | operand2;
            op_and:  result = operand1 & operand2;
            op_eq:   result = {63'd0, operand1 == operand2};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/int_pipe.sv */
`default_nettype none

module int_pipe (
    input  logic              clk,
    input  logic              rst,
    input  logic              abort,
    input  logic              valid,
    output logic              ready,
    input  int_pkg::word_t    pc,
    input  int_pkg::reg_idx_t dst,
    input  logic              wb_en,
    input  int_pkg::alu_op_e  op,
    input  logic              option,
    input  logic              truncate,
    input  int_pkg::br_type_e br_type,
    input  logic              br_neg,
    input  int_pkg::word_t    br_base,
    input  int_pkg::br_off_t  br_offset,
    input  int_pkg::word_t    operand1,
    input  int_pkg::word_t    operand2,
    input  int_pkg::word_t    bt,
    output logic              wb_valid,
    output int_pkg::reg_idx_t wb_dst,
    output int_pkg::word_t    wb_result,
    output int_pkg::word_t    wb_pc,
    output logic              wb_wb_en,
    output logic              wb_hipri,
    input  logic              wb_grant,
    output logic              br_valid,
    output logic              br_override,
    output int_pkg::word_t    br_new_pc
);
    import int_pkg::*;

    word_t alu_result;
    word_t ext_result;
    word_t br_taken_addr;
    word_t br_target;
    logic  is_branch;
    logic  br_take;
    logic  accept;

    alu alu_inst (
        .op       (op),
        .option   (option),
        .operand1 (operand1),
        .operand2 (operand2),
        .result   (alu_result)
    );

    // W-form instructions keep the low word and sign-extend it
    assign ext_result = truncate ? {{32{alu_result[31]}}, alu_result[31:0]} : alu_result;

    assign is_branch = (br_type != bt_none);

    // Jumps always go, a conditional branch follows the ALU compare bit
    always_comb begin
        case (br_type)
            bt_jal, bt_jalr: br_take = 1'b1;
            bt_bcond:        br_take = alu_result[0] ^ br_neg;
            default:         br_take = 1'b0;
        endcase
    end

    // JALR needs bit 0 cleared, the other kinds already have it clear
    assign br_taken_addr = (br_base + {{43{br_offset[20]}}, br_offset}) & ~64'd1;
    assign br_target     = br_take ? br_taken_addr : pc + 64'd4;

    // The output register can take a new entry when empty or when it drains this cycle
    assign ready  = !wb_valid || wb_grant;
    assign accept = valid && ready && !abort;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (abort) begin
            // Flush drops whatever the lane holds
            wb_valid <= 1'b0;
        end else if (ready) begin
            wb_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            wb_dst    <= dst;
            wb_result <= ext_result;
            wb_pc     <= pc;
            wb_wb_en  <= wb_en;
            // Branches get writeback priority so the link value lands early
            wb_hipri  <= is_branch;
        end
    end

    // Branch report is a one-cycle pulse after the branch is accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            br_valid    <= 1'b0;
            br_override <= 1'b0;
        end else begin
            br_valid    <= accept && is_branch;
            br_override <= accept && is_branch && (br_target != bt);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            br_new_pc <= br_target;
        end
    end

endmodule

`default_nettype wire

/* hdl/issue_dispatch.sv */
`default_nettype none

module issue_dispatch #(
    parameter int N_LANES = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    abort,
    input  logic                    redirect,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  int_pkg::word_t          in_pc,
    input  int_pkg::reg_idx_t       in_dst,
    input  logic                    in_wb_en,
    input  int_pkg::alu_op_e        in_op,
    input  logic                    in_option,
    input  logic                    in_truncate,
    input  int_pkg::br_type_e       in_br_type,
    input  logic                    in_br_neg,
    input  int_pkg::word_t          in_br_base,
    input  int_pkg::br_off_t        in_br_offset,
    input  int_pkg::word_t          in_operand1,
    input  int_pkg::word_t          in_operand2,
    input  int_pkg::word_t          in_bt,
    output logic [N_LANES-1:0]      lane_valid,
    input  logic [N_LANES-1:0]      lane_ready,
    output int_pkg::word_t          lane_pc,
    output int_pkg::reg_idx_t       lane_dst,
    output logic                    lane_wb_en,
    output int_pkg::alu_op_e        lane_op,
    output logic                    lane_option,
    output logic                    lane_truncate,
    output int_pkg::br_type_e       lane_br_type,
    output logic                    lane_br_neg,
    output int_pkg::word_t          lane_br_base,
    output int_pkg::br_off_t        lane_br_offset,
    output int_pkg::word_t          lane_operand1,
    output int_pkg::word_t          lane_operand2,
    output int_pkg::word_t          lane_bt
);
    import int_pkg::*;

    localparam int LANE_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    typedef logic [LANE_W-1:0] lane_idx_t;

    lane_idx_t rr_ptr;
    logic      drop;
    logic      dispatch;

    // The op right behind a mispredict is on the wrong path
    // Same goes for anything offered while the pipe flushes
    assign drop     = redirect || abort;
    assign in_ready = drop || lane_ready[rr_ptr];
    assign dispatch = in_valid && !drop && lane_ready[rr_ptr];

    // Only the lane under the pointer is offered the op
    always_comb begin
        lane_valid = '0;
        for (int i = 0; i < N_LANES; i++) begin
            if (rr_ptr == lane_idx_t'(i)) begin
                lane_valid[i] = in_valid && !drop;
            end
        end
    end

    // Strict rotation, a stalled target lane holds up the whole stream
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (dispatch) begin
            if (rr_ptr == lane_idx_t'(N_LANES - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= rr_ptr + 1'b1;
            end
        end
    end

    // All lanes see the same fields and lane_valid picks the one that loads
    assign lane_pc        = in_pc;
    assign lane_dst       = in_dst;
    assign lane_wb_en     = in_wb_en;
    assign lane_op        = in_op;
    assign lane_option    = in_option;
    assign lane_truncate  = in_truncate;
    assign lane_br_type   = in_br_type;
    assign lane_br_neg    = in_br_neg;
    assign lane_br_base   = in_br_base;
    assign lane_br_offset = in_br_offset;
    assign lane_operand1  = in_operand1;
    assign lane_operand2  = in_operand2;
    assign lane_bt        = in_bt;

endmodule

`default_nettype wire

/* hdl/wb_arbiter.sv */
`default_nettype none

module wb_arbiter #(
    parameter int N_LANES = 2
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  abort,
    input  logic              [N_LANES-1:0]       wb_valid,
    input  int_pkg::reg_idx_t [N_LANES-1:0]       wb_dst,
    input  int_pkg::word_t    [N_LANES-1:0]       wb_result,
    input  int_pkg::word_t    [N_LANES-1:0]       wb_pc,
    input  logic              [N_LANES-1:0]       wb_wb_en,
    input  logic              [N_LANES-1:0]       wb_hipri,
    output logic              [N_LANES-1:0]       wb_grant,
    input  logic              [N_LANES-1:0]       br_valid,
    input  logic              [N_LANES-1:0]       br_override,
    input  int_pkg::word_t    [N_LANES-1:0]       br_new_pc,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output int_pkg::reg_idx_t                     out_dst,
    output int_pkg::word_t                        out_result,
    output int_pkg::word_t                        out_pc,
    output logic                                  out_wb_en,
    output logic                                  redirect,
    output int_pkg::word_t                        redirect_pc
);
    import int_pkg::*;

    localparam int LANE_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    typedef logic [LANE_W-1:0] lane_idx_t;

    lane_idx_t          rr_ptr;
    lane_idx_t          sel;
    logic [LANE_W:0]    hi_pick;
    logic [LANE_W:0]    any_pick;
    logic               take;
    logic [N_LANES-1:0] reports;

    // First requester at or after start, returned as {found, index}
    // Walking down means the last hit is the one closest to start
    function automatic logic [LANE_W:0] pick(input logic [N_LANES-1:0] req,
                                              input lane_idx_t start);
        logic [LANE_W:0] res;
        int              idx;
        res = '0;
        for (int k = N_LANES - 1; k >= 0; k--) begin
            idx = int'(start) + k;
            if (idx >= N_LANES) begin
                idx = idx - N_LANES;
            end
            if (req[idx]) begin
                res = {1'b1, lane_idx_t'(idx)};
            end
        end
        return res;
    endfunction

    assign hi_pick  = pick(wb_valid & wb_hipri, rr_ptr);
    assign any_pick = pick(wb_valid, rr_ptr);

    // Branch results win over plain ones
    assign sel = hi_pick[LANE_W] ? hi_pick[LANE_W-1:0] : any_pick[LANE_W-1:0];

    // Nothing leaves during a flush
    assign out_valid  = any_pick[LANE_W] && !abort;
    assign out_dst    = wb_dst[sel];
    assign out_result = wb_result[sel];
    assign out_pc     = wb_pc[sel];
    assign out_wb_en  = wb_wb_en[sel];

    assign take = out_valid && out_ready;

    always_comb begin
        wb_grant = '0;
        if (take) begin
            wb_grant[sel] = 1'b1;
        end
    end

    // Pointer moves past the lane that was just served
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (take) begin
            if (sel == lane_idx_t'(N_LANES - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= sel + 1'b1;
            end
        end
    end

    // At most one lane reports a mispredict per cycle
    // The lowest lane wins anyway so the mux is well defined
    assign reports  = br_valid & br_override;
    assign redirect = |reports;

    always_comb begin
        redirect_pc = br_new_pc[0];
        for (int i = N_LANES - 1; i >= 0; i--) begin
            if (reports[i]) begin
                redirect_pc = br_new_pc[i];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/int_cluster_top.sv */
`default_nettype none

module int_cluster_top #(
    parameter int N_LANES = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              abort,
    input  logic              in_valid,
    output logic              in_ready,
    input  int_pkg::word_t    in_pc,
    input  int_pkg::reg_idx_t in_dst,
    input  logic              in_wb_en,
    input  int_pkg::alu_op_e  in_op,
    input  logic              in_option,
    input  logic              in_truncate,
    input  int_pkg::br_type_e in_br_type,
    input  logic              in_br_neg,
    input  int_pkg::word_t    in_br_base,
    input  int_pkg::br_off_t  in_br_offset,
    input  int_pkg::word_t    in_operand1,
    input  int_pkg::word_t    in_operand2,
    input  int_pkg::word_t    in_bt,
    output logic              out_valid,
    input  logic              out_ready,
    output int_pkg::reg_idx_t out_dst,
    output int_pkg::word_t    out_result,
    output int_pkg::word_t    out_pc,
    output logic              out_wb_en,
    output logic              redirect,
    output int_pkg::word_t    redirect_pc
);
    import int_pkg::*;

    // Operation fields shared by all lanes
    logic [N_LANES-1:0] lane_valid;
    logic [N_LANES-1:0] lane_ready;
    word_t              lane_pc;
    reg_idx_t           lane_dst;
    logic               lane_wb_en;
    alu_op_e            lane_op;
    logic               lane_option;
    logic               lane_truncate;
    br_type_e           lane_br_type;
    logic               lane_br_neg;
    word_t              lane_br_base;
    br_off_t            lane_br_offset;
    word_t              lane_operand1;
    word_t              lane_operand2;
    word_t              lane_bt;

    // Per-lane result and branch report
    logic     [N_LANES-1:0] wb_valid;
    reg_idx_t [N_LANES-1:0] wb_dst;
    word_t    [N_LANES-1:0] wb_result;
    word_t    [N_LANES-1:0] wb_pc;
    logic     [N_LANES-1:0] wb_wb_en;
    logic     [N_LANES-1:0] wb_hipri;
    logic     [N_LANES-1:0] wb_grant;
    logic     [N_LANES-1:0] br_valid;
    logic     [N_LANES-1:0] br_override;
    word_t    [N_LANES-1:0] br_new_pc;

    // Names match the dispatcher and arbiter ports one to one
    issue_dispatch #(.N_LANES(N_LANES)) issue_dispatch_inst (.*);

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        int_pipe int_pipe_inst (
            .clk         (clk),
            .rst         (rst),
            .abort       (abort),
            .valid       (lane_valid[i]),
            .ready       (lane_ready[i]),
            .pc          (lane_pc),
            .dst         (lane_dst),
            .wb_en       (lane_wb_en),
            .op          (lane_op),
            .option      (lane_option),
            .truncate    (lane_truncate),
            .br_type     (lane_br_type),
            .br_neg      (lane_br_neg),
            .br_base     (lane_br_base),
            .br_offset   (lane_br_offset),
            .operand1    (lane_operand1),
            .operand2    (lane_operand2),
            .bt          (lane_bt),
            .wb_valid    (wb_valid[i]),
            .wb_dst      (wb_dst[i]),
            .wb_result   (wb_result[i]),
            .wb_pc       (wb_pc[i]),
            .wb_wb_en    (wb_wb_en[i]),
            .wb_hipri    (wb_hipri[i]),
            .wb_grant    (wb_grant[i]),
            .br_valid    (br_valid[i]),
            .br_override (br_override[i]),
            .br_new_pc   (br_new_pc[i])
        );
    end

    wb_arbiter #(.N_LANES(N_LANES)) wb_arbiter_inst (.*);

endmodule

`default_nettype wire

/* bench/int_cluster_tb.sv */
`default_nettype none

module int_cluster_tb;
    import int_pkg::*;

    // One row of the stimulus table together with the outcome it must produce
    typedef struct {
        word_t    pc;
        alu_op_e  op;
        logic     option;
        logic     truncate;
        br_type_e br_type;
        logic     br_neg;
        word_t    br_base;
        br_off_t  br_offset;
        word_t    operand1;
        word_t    operand2;
        word_t    bt;
        reg_idx_t dst;
        logic     wb_en;
        logic     drop;
        logic     flush;
        word_t    result;
        logic     redir;
        word_t    redir_pc;
    } entry_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     abort;
    logic     in_valid;
    logic     in_ready;
    word_t    in_pc;
    reg_idx_t in_dst;
    logic     in_wb_en;
    alu_op_e  in_op;
    logic     in_option;
    logic     in_truncate;
    br_type_e in_br_type;
    logic     in_br_neg;
    word_t    in_br_base;
    br_off_t  in_br_offset;
    word_t    in_operand1;
    word_t    in_operand2;
    word_t    in_bt;
    logic     out_valid;
    logic     out_ready = 1'b0;
    reg_idx_t out_dst;
    word_t    out_result;
    word_t    out_pc;
    logic     out_wb_en;
    logic     redirect;
    word_t    redirect_pc;

    entry_t      tbl[$];
    bit          seen[64];
    logic [31:0] lfsr = 32'h3184_b1f9;
    int          cur = 0;
    int          last_acc = -1;
    int          live_count = 0;
    int          wb_count = 0;
    int          errors = 0;
    int          checks = 0;

    int_cluster_top #(.N_LANES(2)) int_cluster_top_inst (.*);

    always #2 clk = ~clk;

    // Fibonacci LFSR over x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // The writeback side takes one fresh LFSR bit per cycle as its ready
    always @(posedge clk) begin
        lfsr = lfsr_step(lfsr);
        out_ready <= lfsr[0];
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    function automatic int find_entry(input word_t pc);
        for (int j = 0; j < tbl.size(); j++) begin
            if (tbl[j].pc == pc) begin
                return j;
            end
        end
        return -1;
    endfunction

    // Each row gets its own pc from its position, so writebacks can be traced by pc
    function automatic entry_t blank_row();
        entry_t e;
        e.pc        = 64'h1000 + 64'(tbl.size()) * 64'd4;
        e.op        = op_add;
        e.option    = 1'b0;
        e.truncate  = 1'b0;
        e.br_type   = bt_none;
        e.br_neg    = 1'b0;
        e.br_base   = '0;
        e.br_offset = '0;
        e.operand1  = '0;
        e.operand2  = '0;
        e.bt        = e.pc + 64'd4;
        e.dst       = 5'(tbl.size());
        e.wb_en     = (tbl.size() % 4) != 3;
        e.drop      = 1'b0;
        e.flush     = 1'b0;
        e.result    = '0;
        e.redir     = 1'b0;
        e.redir_pc  = '0;
        return e;
    endfunction

    task automatic alu_row(input alu_op_e op, input logic option, input logic truncate,
                           input word_t a, input word_t b, input word_t res);
        entry_t e;
        e          = blank_row();
        e.op       = op;
        e.option   = option;
        e.truncate = truncate;
        e.operand1 = a;
        e.operand2 = b;
        e.result   = res;
        tbl.push_back(e);
    endtask

    // Jumps feed pc and 4 to the adder for the link value, conditionals feed the compare
    task automatic branch_row(input br_type_e kind, input alu_op_e op, input logic neg,
                              input word_t a, input word_t b, input word_t base,
                              input br_off_t off, input word_t bt, input word_t res,
                              input logic redir, input word_t target);
        entry_t e;
        e           = blank_row();
        e.br_type   = kind;
        e.op        = op;
        e.br_neg    = neg;
        e.operand1  = a;
        e.operand2  = b;
        e.br_base   = base;
        e.br_offset = off;
        e.bt        = bt;
        e.result    = res;
        e.redir     = redir;
        e.redir_pc  = target;
        if (kind == bt_bcond) begin
            e.wb_en = 1'b0;
        end
        tbl.push_back(e);
    endtask

    task automatic drop_row(input logic flush);
        entry_t e;
        e          = blank_row();
        e.drop     = 1'b1;
        e.flush    = flush;
        e.operand1 = 64'd9;
        e.operand2 = 64'd9;
        tbl.push_back(e);
    endtask

    // Expected values are worked out by hand from the ALU and branch rules
    task automatic load_table();
        alu_row(op_add, 1'b0, 1'b0, 64'd5, 64'd7, 64'hc);
        alu_row(op_add, 1'b1, 1'b0, 64'd5, 64'd7, 64'hffff_ffff_ffff_fffe);
        // Shift amount 0x43 keeps only its low six bits
        alu_row(op_sll, 1'b0, 1'b0, 64'd1, 64'h43, 64'h8);
        alu_row(op_sll, 1'b1, 1'b0, 64'd3, 64'd1, 64'h6);
        alu_row(op_slt, 1'b0, 1'b0, '1, 64'd1, 64'h1);
        alu_row(op_sltu, 1'b1, 1'b0, '1, 64'd1, 64'h0);
        alu_row(op_xor, 1'b0, 1'b0, 64'hf0f0, 64'h0ff0, 64'hff00);
        alu_row(op_srl, 1'b0, 1'b0, 64'h8000_0000_0000_0000, 64'd4, 64'h0800_0000_0000_0000);
        alu_row(op_srl, 1'b1, 1'b0, 64'h8000_0000_0000_0000, 64'd4, 64'hf800_0000_0000_0000);
        alu_row(op_or, 1'b1, 1'b0, 64'h0f, 64'hf0, 64'hff);
        alu_row(op_and, 1'b0, 1'b0, 64'hff, 64'h3c, 64'h3c);
        alu_row(op_eq, 1'b1, 1'b0, 64'h1234, 64'h1234, 64'h1);
        // Word forms sign-extend bit 31 of the raw result
        alu_row(op_add, 1'b0, 1'b1, 64'h7fff_ffff, 64'd1, 64'hffff_ffff_8000_0000);
        alu_row(op_sll, 1'b0, 1'b1, 64'h1_8000_0001, 64'd4, 64'h10);
        // Mispredicted JAL, JALR, taken and untaken conditionals, each with a victim
        branch_row(bt_jal, op_add, 1'b0, 64'h1038, 64'd4, 64'h1038, 21'h100,
                   64'h103c, 64'h103c, 1'b1, 64'h1138);
        drop_row(1'b0);
        branch_row(bt_jalr, op_add, 1'b0, 64'h1040, 64'd4, 64'h2001, -21'sd4,
                   64'h2000, 64'h1044, 1'b1, 64'h1ffc);
        drop_row(1'b0);
        branch_row(bt_bcond, op_eq, 1'b0, 64'd3, 64'd3, 64'h1048, 21'h20,
                   64'h104c, 64'h1, 1'b1, 64'h1068);
        drop_row(1'b0);
        branch_row(bt_bcond, op_eq, 1'b1, 64'd3, 64'd3, 64'h1050, 21'h40,
                   64'h1090, 64'h1, 1'b1, 64'h1054);
        drop_row(1'b0);
        // Correct predictions let the next operation through
        branch_row(bt_bcond, op_slt, 1'b0, 64'd1, 64'd2, 64'h1058, -21'sd8,
                   64'h1050, 64'h1, 1'b0, 64'h0);
        alu_row(op_xor, 1'b0, 1'b0, 64'haa, 64'h55, 64'hff);
        branch_row(bt_jal, op_add, 1'b0, 64'h1060, 64'd4, 64'h1060, 21'h10,
                   64'h1070, 64'h1064, 1'b0, 64'h0);
        alu_row(op_or, 1'b0, 1'b0, 64'h100, 64'h1, 64'h101);
        // Flush while one operation still sits in its lane, then normal traffic again
        drop_row(1'b0);
        drop_row(1'b1);
        alu_row(op_and, 1'b0, 1'b0, 64'hf0f0, 64'hff00, 64'hf000);
        alu_row(op_add, 1'b0, 1'b0, 64'h10, 64'h20, 64'h30);
    endtask

    task automatic drive_entry(input int i);
        in_valid     <= 1'b1;
        abort        <= tbl[i].flush;
        in_pc        <= tbl[i].pc;
        in_dst       <= tbl[i].dst;
        in_wb_en     <= tbl[i].wb_en;
        in_op        <= tbl[i].op;
        in_option    <= tbl[i].option;
        in_truncate  <= tbl[i].truncate;
        in_br_type   <= tbl[i].br_type;
        in_br_neg    <= tbl[i].br_neg;
        in_br_base   <= tbl[i].br_base;
        in_br_offset <= tbl[i].br_offset;
        in_operand1  <= tbl[i].operand1;
        in_operand2  <= tbl[i].operand2;
        in_bt        <= tbl[i].bt;
    endtask

    // Outputs are sampled on the falling edge, half a cycle away from any change
    always @(negedge clk) begin
        int   k;
        logic expect_redir;
        if (rst) begin
            check("out_valid", 64'(out_valid), 64'd0);
            check("redirect", 64'(redirect), 64'd0);
        end else begin
            // A mispredict shows up one cycle after its branch was taken in
            expect_redir = 1'b0;
            if (last_acc >= 0) begin
                expect_redir = tbl[last_acc].redir;
            end
            check("redirect", 64'(redirect), 64'(expect_redir));
            if (expect_redir) begin
                check("redirect_pc", redirect_pc, tbl[last_acc].redir_pc);
            end
            if (abort) begin
                check("out_valid", 64'(out_valid), 64'd0);
            end
            // Writeback that completes at the coming rising edge
            if (out_valid && out_ready) begin
                k = find_entry(out_pc);
                if ($isunknown(out_pc) || k < 0) begin
                    errors++;
                    $display("Writeback with a pc that is not in the table: %h", out_pc);
                end else if (tbl[k].drop) begin
                    errors++;
                    $display("Dropped operation at pc %h was written back", out_pc);
                end else if (seen[k]) begin
                    errors++;
                    $display("Operation at pc %h was written back twice", out_pc);
                end else begin
                    seen[k] = 1'b1;
                    wb_count++;
                    check("out_result", out_result, tbl[k].result);
                    check("out_dst", 64'(out_dst), 64'(tbl[k].dst));
                    check("out_wb_en", 64'(out_wb_en), 64'(tbl[k].wb_en));
                end
            end
            // Issue handshake that completes at the coming rising edge
            if (in_valid && in_ready) begin
                last_acc = cur;
                if (!tbl[cur].drop) begin
                    live_count++;
                end
            end else begin
                last_acc = -1;
            end
        end
    end

    initial begin
        int i;
        int missing;
        load_table();
        rst          = 1'b1;
        abort        = 1'b0;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_dst       = '0;
        in_wb_en     = 1'b0;
        in_op        = op_add;
        in_option    = 1'b0;
        in_truncate  = 1'b0;
        in_br_type   = bt_none;
        in_br_neg    = 1'b0;
        in_br_base   = '0;
        in_br_offset = '0;
        in_operand1  = '0;
        in_operand2  = '0;
        in_bt        = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < tbl.size(); i++) begin
            // The lanes drain ahead of the row that comes just before a flush
            // That row is then the only result a lane holds when the flush arrives
            if (i + 1 < tbl.size() && tbl[i + 1].flush) begin
                in_valid <= 1'b0;
                while (wb_count != live_count) @(posedge clk);
            end
            drive_entry(i);
            cur = i;
            do @(negedge clk); while (!in_ready);
            @(posedge clk);
        end
        in_valid <= 1'b0;
        abort    <= 1'b0;
        while (wb_count != live_count) @(posedge clk);
        // Idle time to catch late duplicates
        repeat (20) @(posedge clk);
        missing = 0;
        for (i = 0; i < tbl.size(); i++) begin
            if (!tbl[i].drop && !seen[i]) begin
                missing++;
                $display("Operation at pc %h was never written back", tbl[i].pc);
            end
        end
        $display("Summary: %0d checks, %0d errors, %0d missing writebacks",
                 checks, errors, missing);
        if (errors == 0 && missing == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Budget of 40 cycles per table row
    initial begin
        @(negedge rst);
        repeat (tbl.size() * 40) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", tbl.size() * 40);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/int_pkg.sv
hdl/alu.sv
hdl/int_pipe.sv
hdl/issue_dispatch.sv
hdl/wb_arbiter.sv
hdl/int_cluster_top.sv
bench/int_cluster_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the integer cluster testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module int_cluster_tb -o int_cluster_sim
./obj_dir/int_cluster_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
